//--- design/exu_alu.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_alu import exu_pkg::*; (
    input  alu_op_e              aluop,
    input  logic [`EXU_XLEN-1:0] a,
    input  logic [`EXU_XLEN-1:0] b,
    input  logic                 shift_word,
    output logic [`EXU_XLEN-1:0] result,
    output alu_flags_t           flags
);

    logic [`EXU_XLEN:0]   diff;
    logic                 lt;
    logic [5:0]           shamt;
    logic [`EXU_XLEN-1:0] srl_src;
    logic [`EXU_XLEN-1:0] sra_src;

    // One subtraction with an extra borrow bit feeds every compare.
    assign diff = {1'b0, a} - {1'b0, b};

    // With differing signs the negative operand is the smaller one.
    assign lt = (a[`EXU_XLEN-1] ^ b[`EXU_XLEN-1]) ? a[`EXU_XLEN-1] : diff[`EXU_XLEN-1];

    always_comb begin
        flags.lt   = lt;
        flags.ltu  = diff[`EXU_XLEN];
        flags.zero = (diff[`EXU_XLEN-1:0] == '0);
    end

    // Word shifts take a 5-bit amount and work on the low half only.
    assign shamt = shift_word ? {1'b0, b[4:0]} : b[5:0];

    assign srl_src = shift_word ? {{(`EXU_XLEN-32){1'b0}}, a[31:0]} : a;

    // For sraw the sign comes from bit 31.
    assign sra_src = shift_word ? {{(`EXU_XLEN-32){a[31]}}, a[31:0]} : a;

    always_comb begin
        case (aluop)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = diff[`EXU_XLEN-1:0];
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_slt: begin
                result = {{(`EXU_XLEN-1){1'b0}}, lt};
            end
            alu_sltu: begin
                result = {{(`EXU_XLEN-1){1'b0}}, diff[`EXU_XLEN]};
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_srl: begin
                result = srl_src >> shamt;
            end
            alu_sra: begin
                result = $signed(sra_src) >>> shamt;
            end
            alu_or: begin
                result = a | b;
            end
            alu_and: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- design/exu_bcu.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_bcu import exu_pkg::*; (
    input  bcu_op_e              bcuop,
    input  alu_flags_t           flags,
    input  logic [`EXU_XLEN-1:0] pc,
    input  logic [`EXU_XLEN-1:0] offset,
    output logic                 jump,
    output logic [`EXU_XLEN-1:0] dnpc
);

    logic [`EXU_XLEN-1:0] taken_pc;
    logic [`EXU_XLEN-1:0] next_pc;

    assign taken_pc = pc + offset;
    assign next_pc  = pc + `EXU_INST_BYTES;

    always_comb begin
        case (bcuop)
            bcu_beq: begin
                jump = flags.zero;
            end
            bcu_bne: begin
                jump = !flags.zero;
            end
            bcu_blt: begin
                jump = flags.lt;
            end
            bcu_bge: begin
                jump = !flags.lt;
            end
            bcu_bltu: begin
                jump = flags.ltu;
            end
            bcu_bgeu: begin
                jump = !flags.ltu;
            end
            bcu_jal: begin
                jump = 1'b1;
            end
            default: begin
                jump = 1'b0;
            end
        endcase
    end

    // A branch that is not taken falls through to the next instruction.
    assign dnpc = jump ? taken_pc : next_pc;

endmodule

//--- design/exu_config.svh
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// Data and address width of the RV64 datapath.
`define EXU_XLEN 64

// Width of the ALU operation field carried in the decoded bundle.
`define EXU_ALUOP_W 4

// Width of the branch operation field.
`define EXU_BCUOP_W 3

// Width of the operand-source select.
`define EXU_OPSEL_W 2

// Size of one instruction in bytes, used for the link and fall-through PC.
`define EXU_INST_BYTES 4

`endif

//--- design/exu_core.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_core import exu_pkg::*; (
    input  ex_in_t  in,
    output ex_out_t out
);

    logic [`EXU_XLEN-1:0] alu_b;
    logic [`EXU_XLEN-1:0] alu_result;
    alu_flags_t           flags;
    logic                 bcu_jump;
    logic [`EXU_XLEN-1:0] bcu_dnpc;
    logic                 is_auipc;
    logic                 is_lui;
    logic                 is_jalr;
    logic                 is_jal;
    logic [`EXU_XLEN-1:0] adder_a;
    logic [`EXU_XLEN-1:0] adder_b;
    logic [`EXU_XLEN-1:0] adder_result;
    logic [`EXU_XLEN-1:0] jalr_sum;

    // Address generation replaces op2 with the immediate.
    assign alu_b = (in.opsel == opsel_imm) ? in.offset : in.op2;

    exu_alu u_alu (
        .aluop      (in.aluop),
        .a          (in.op1),
        .b          (alu_b),
        .shift_word (in.shift_word),
        .result     (alu_result),
        .flags      (flags)
    );

    exu_bcu u_bcu (
        .bcuop  (in.bcuop),
        .flags  (flags),
        .pc     (in.pc),
        .offset (in.offset),
        .jump   (bcu_jump),
        .dnpc   (bcu_dnpc)
    );

    assign is_auipc = (in.aluop == alu_auipc);
    assign is_lui   = (in.aluop == alu_lui);
    assign is_jalr  = (in.aluop == alu_jalr);
    assign is_jal   = (in.bcuop == bcu_jal);

    // Shared adder for auipc, lui and the link address of jal and jalr.
    assign adder_a      = is_lui ? '0 : in.pc;
    assign adder_b      = (is_auipc || is_lui) ? (in.op2 << 12) : `EXU_INST_BYTES;
    assign adder_result = adder_a + adder_b;

    assign jalr_sum = in.op1 + in.offset;

    always_comb begin
        if (is_auipc || is_lui || is_jal || is_jalr) begin
            out.result = adder_result;
        end else if (in.word) begin
            out.result = {{(`EXU_XLEN-32){alu_result[31]}}, alu_result[31:0]};
        end else begin
            out.result = alu_result;
        end
        out.jump  = is_jalr || bcu_jump;
        out.dnpc  = is_jalr ? {jalr_sum[`EXU_XLEN-1:1], 1'b0} : bcu_dnpc;
        out.mdata = in.op2;
    end

endmodule

//--- design/exu_pkg.sv
`include "exu_config.svh"

package exu_pkg;

    // The last three codes are not ALU functions; they steer the core's adder.
    typedef enum logic [`EXU_ALUOP_W-1:0] {
        alu_add   = 4'b0000,
        alu_sub   = 4'b0001,
        alu_sll   = 4'b0010,
        alu_slt   = 4'b0011,
        alu_sltu  = 4'b0100,
        alu_xor   = 4'b0101,
        alu_srl   = 4'b0110,
        alu_sra   = 4'b0111,
        alu_or    = 4'b1000,
        alu_and   = 4'b1001,
        alu_auipc = 4'b1010,
        alu_lui   = 4'b1011,
        alu_jalr  = 4'b1100
    } alu_op_e;

    typedef enum logic [`EXU_BCUOP_W-1:0] {
        bcu_none = 3'b000,
        bcu_beq  = 3'b001,
        bcu_bne  = 3'b010,
        bcu_blt  = 3'b011,
        bcu_bge  = 3'b100,
        bcu_bltu = 3'b101,
        bcu_bgeu = 3'b110,
        bcu_jal  = 3'b111
    } bcu_op_e;

    // Source of the ALU's second operand.
    typedef enum logic [`EXU_OPSEL_W-1:0] {
        opsel_reg = 2'b00,
        opsel_imm = 2'b01
    } opsel_e;

    typedef struct packed {
        alu_op_e              aluop;
        bcu_op_e              bcuop;
        logic [`EXU_XLEN-1:0] op1;
        logic [`EXU_XLEN-1:0] op2;
        logic [`EXU_XLEN-1:0] pc;
        logic [`EXU_XLEN-1:0] offset;
        opsel_e               opsel;
        logic                 word;
        logic                 shift_word;
    } ex_in_t;

    typedef struct packed {
        logic [`EXU_XLEN-1:0] result;
        logic [`EXU_XLEN-1:0] dnpc;
        logic                 jump;
        logic [`EXU_XLEN-1:0] mdata;
    } ex_out_t;

    typedef struct packed {
        logic lt;
        logic ltu;
        logic zero;
    } alu_flags_t;

endpackage

//--- design/exu_stage.sv
`timescale 1ns/1ps

module exu_stage import exu_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  ex_in_t  in,
    output logic    out_valid,
    output ex_out_t out
);

    ex_out_t core_out;

    exu_core u_core (
        .in  (in),
        .out (core_out)
    );

    // The valid flag follows the strobe with one cycle of delay.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Results are captured only on a strobe and held otherwise.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out <= '0;
        end else if (in_valid) begin
            out <= core_out;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exu_tb -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vexu_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

//--- sim/exu_assertions.sv
`timescale 1ns/1ps

module exu_assertions import exu_pkg::*; (
    input logic    clk,
    input logic    arst_n,
    input logic    in_valid,
    input ex_in_t  in,
    input logic    out_valid,
    input ex_out_t out
);

    logic [$bits(ex_out_t)-1:0] out_bits;
    logic                       jalr_in;

    assign out_bits = out;
    assign jalr_in  = in_valid && (in.aluop == alu_jalr);

    // The valid flag is the strobe delayed by one cycle.
    valid_follows_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid))
        else $error("out_valid does not follow in_valid of the previous cycle");

    // Without a strobe the output register keeps its value.
    out_held: assert property (@(posedge clk) disable iff (!arst_n)
        !out_valid |-> $stable(out_bits))
        else $error("out changed while out_valid was low");

    // A jalr target always lands on an even address.
    jalr_even: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && out.jump && $past(jalr_in)) |-> !out.dnpc[0])
        else $error("jalr target has bit 0 set");

endmodule

//--- sim/exu_tb.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_tb import exu_pkg::*; ();

    localparam int num_vec        = 134;
    localparam int cycles_per_vec = 4;
    localparam int watchdog_ns    = (num_vec * cycles_per_vec + 20) * 100;

    logic    clk;
    logic    arst_n;
    logic    in_valid;
    ex_in_t  vec_in;
    logic    out_valid;
    ex_out_t dut_out;
    int      errors;
    int      checks;

    exu_stage u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in        (vec_in),
        .out_valid (out_valid),
        .out       (dut_out)
    );

    bind exu_stage exu_assertions u_assertions (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in        (in),
        .out_valid (out_valid),
        .out       (out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [`EXU_XLEN-1:0] rand64();
        return {$urandom(), $urandom()};
    endfunction

    // Random immediate of the given width, sign-extended to the full word.
    function automatic logic [`EXU_XLEN-1:0] rand_imm(input int bits);
        logic [`EXU_XLEN-1:0] r;
        r = rand64() << (`EXU_XLEN - bits);
        return $signed(r) >>> (`EXU_XLEN - bits);
    endfunction

    function automatic ex_in_t make_in(input alu_op_e aluop, input bcu_op_e bcuop,
                                       input logic [`EXU_XLEN-1:0] op1,
                                       input logic [`EXU_XLEN-1:0] op2,
                                       input logic [`EXU_XLEN-1:0] offset);
        ex_in_t v;
        v = '0;
        v.aluop = aluop;
        v.bcuop = bcuop;
        v.op1 = op1;
        v.op2 = op2;
        v.pc = rand64() & ~64'd3;
        v.offset = offset;
        v.opsel = opsel_reg;
        return v;
    endfunction

    // Reference model of the execute stage.
    function automatic ex_out_t predict(input ex_in_t v);
        ex_out_t              e;
        logic [`EXU_XLEN-1:0] b;
        logic [`EXU_XLEN-1:0] r;
        logic [5:0]           amt;
        logic                 cond;
        b = (v.opsel == opsel_imm) ? v.offset : v.op2;
        amt = v.shift_word ? {1'b0, b[4:0]} : b[5:0];
        case (v.aluop)
            alu_add:  r = v.op1 + b;
            alu_sub:  r = v.op1 - b;
            alu_sll:  r = v.op1 << amt;
            alu_slt:  r = {63'b0, $signed(v.op1) < $signed(b)};
            alu_sltu: r = {63'b0, v.op1 < b};
            alu_xor:  r = v.op1 ^ b;
            alu_srl:  r = v.shift_word ? {32'b0, v.op1[31:0] >> amt} : v.op1 >> amt;
            alu_sra: begin
                if (v.shift_word) begin
                    r = {{32{v.op1[31]}}, $signed(v.op1[31:0]) >>> amt};
                end else begin
                    r = $signed(v.op1) >>> amt;
                end
            end
            alu_or:   r = v.op1 | b;
            alu_and:  r = v.op1 & b;
            default:  r = 0;
        endcase
        if (v.word) begin
            r = {{32{r[31]}}, r[31:0]};
        end
        case (v.bcuop)
            bcu_beq:  cond = (v.op1 == b);
            bcu_bne:  cond = (v.op1 != b);
            bcu_blt:  cond = ($signed(v.op1) < $signed(b));
            bcu_bge:  cond = ($signed(v.op1) >= $signed(b));
            bcu_bltu: cond = (v.op1 < b);
            bcu_bgeu: cond = (v.op1 >= b);
            bcu_jal:  cond = 1'b1;
            default:  cond = 1'b0;
        endcase
        if (v.aluop == alu_lui) begin
            r = v.op2 << 12;
        end else if (v.aluop == alu_auipc) begin
            r = v.pc + (v.op2 << 12);
        end else if (v.aluop == alu_jalr || v.bcuop == bcu_jal) begin
            r = v.pc + 4;
        end
        e.result = r;
        e.jump = cond || (v.aluop == alu_jalr);
        if (v.aluop == alu_jalr) begin
            e.dnpc = (v.op1 + v.offset) & ~64'd1;
        end else begin
            e.dnpc = cond ? v.pc + v.offset : v.pc + 4;
        end
        e.mdata = v.op2;
        return e;
    endfunction

    task automatic check_field(input string name, input logic [`EXU_XLEN-1:0] got,
                               input logic [`EXU_XLEN-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_out(input ex_out_t exp);
        check_field("out.result", dut_out.result, exp.result);
        check_field("out.dnpc", dut_out.dnpc, exp.dnpc);
        check_field("out.jump", {63'b0, dut_out.jump}, {63'b0, exp.jump});
        check_field("out.mdata", dut_out.mdata, exp.mdata);
    endtask

    // Sends one strobe, waits for the single out_valid pulse and checks it.
    task automatic run_vec(input ex_in_t v);
        ex_out_t exp;
        int      waited;
        exp = predict(v);
        waited = 0;
        @(posedge clk);
        vec_in <= v;
        in_valid <= 1'b1;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        while (!out_valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        assert (out_valid) else begin
            errors++;
            $display("out_valid did not rise after the strobe");
        end
        compare_out(exp);
        @(negedge clk);
        assert (!out_valid) else begin
            errors++;
            $display("out_valid stayed high for more than one cycle");
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        assert (!out_valid && dut_out == '0) else begin
            errors++;
            $display("outputs were not cleared by the reset");
        end
    endtask

    task automatic test_alu_ops();
        logic [`EXU_XLEN-1:0] corner [6];
        int                   op;
        int                   k;
        corner = '{64'd0, 64'd1, '1, 64'h8000_0000_0000_0000,
                   64'h7fff_ffff_ffff_ffff, 64'h0000_0000_8000_0000};
        for (op = 0; op < 10; op++) begin
            for (k = 0; k < 8; k++) begin
                if (k < 6) begin
                    run_vec(make_in(alu_op_e'(op), bcu_none, corner[k], corner[5-k], 0));
                end else begin
                    run_vec(make_in(alu_op_e'(op), bcu_none, rand64(), rand64(), 0));
                end
            end
        end
    endtask

    task automatic test_alu_stream();
        ex_in_t v [16];
        int     i;
        for (i = 0; i < 16; i++) begin
            v[i] = make_in(alu_op_e'(i % 10), bcu_none, rand64(), rand64(), 0);
        end
        @(posedge clk);
        vec_in <= v[0];
        in_valid <= 1'b1;
        for (i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i < 15) begin
                vec_in <= v[i+1];
            end else begin
                in_valid <= 1'b0;
            end
            @(negedge clk);
            assert (out_valid) else begin
                errors++;
                $display("out_valid dropped during a back-to-back stream");
            end
            compare_out(predict(v[i]));
        end
    endtask

    task automatic test_word_ops();
        ex_in_t v;
        int     k;
        v = make_in(alu_add, bcu_none, 64'h0000_0000_7fff_ffff, 64'd1, 0);
        v.word = 1'b1;
        run_vec(v);
        v = make_in(alu_sub, bcu_none, rand64(), rand64(), 0);
        v.word = 1'b1;
        run_vec(v);
        // Bit 5 of the amount is set so that a 6-bit shift would differ.
        for (k = 0; k < 6; k++) begin
            v = make_in(alu_op_e'(k < 2 ? alu_sll : (k < 4 ? alu_srl : alu_sra)), bcu_none,
                        rand64() | 64'h8000_0000, rand64() | 64'h20, 0);
            v.word = 1'b1;
            v.shift_word = 1'b1;
            run_vec(v);
        end
        for (k = 0; k < 3; k++) begin
            v = make_in(alu_add, bcu_none, rand64(), rand64(), rand_imm(12));
            v.opsel = opsel_imm;
            run_vec(v);
        end
    endtask

    task automatic test_branches();
        logic [`EXU_XLEN-1:0] pa [3];
        logic [`EXU_XLEN-1:0] pb [3];
        int                   op;
        int                   k;
        pa = '{64'd5, '1, 64'd1};
        pb = '{64'd5, 64'd1, '1};
        for (op = 1; op < 7; op++) begin
            for (k = 0; k < 3; k++) begin
                run_vec(make_in(alu_sub, bcu_op_e'(op), pa[k], pb[k], rand_imm(13) & ~64'd1));
            end
        end
        run_vec(make_in(alu_sub, bcu_none, 64'd5, 64'd5, rand_imm(13) & ~64'd1));
    endtask

    task automatic test_jumps();
        int k;
        for (k = 0; k < 2; k++) begin
            run_vec(make_in(alu_add, bcu_jal, rand64(), rand64(), rand_imm(21) & ~64'd1));
            // An odd base plus an even offset is odd, so bit 0 has to be cleared.
            run_vec(make_in(alu_jalr, bcu_none, rand64() | 64'd1, rand64(),
                            rand_imm(12) & ~64'd1));
            run_vec(make_in(alu_lui, bcu_none, rand64(), rand_imm(20), 0));
            run_vec(make_in(alu_auipc, bcu_none, rand64(), rand_imm(20), 0));
        end
    endtask

    initial begin
        arst_n = 1'b0;
        in_valid = 1'b0;
        vec_in = '0;
        errors = 0;
        checks = 0;
        void'($urandom(32'hefa01950));
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        test_reset();
        test_alu_ops();
        test_alu_stream();
        test_word_ops();
        test_branches();
        test_jumps();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+design
design/exu_pkg.sv
design/exu_alu.sv
design/exu_bcu.sv
design/exu_core.sv
design/exu_stage.sv
sim/exu_assertions.sv
sim/exu_tb.sv
